//--- logic/ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Machine widths shared by the execution cluster

// Data path width, RV32
`define XLEN 32

// Physical register file index width, 64 entries
`define PRF_LEN 6

// Reorder buffer index width, 32 entries
`define ROB_LEN 5

`endif

//--- logic/ooo_pkg.sv
`include "ooo_cfg.svh"

package ooo_pkg;

	// Widths with a meaning of their own
	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [`PRF_LEN-1:0] preg_idx_t;
	typedef logic [`ROB_LEN-1:0] rob_idx_t;
	typedef logic [31:0] inst_t;

	// Operand A source
	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_NPC  = 2'h1,
		OPA_IS_PC   = 2'h2,
		OPA_IS_ZERO = 2'h3
	} opa_select_e;

	// Operand B source, codes 6 and 7 unused
	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} opb_select_e;

	// Integer ALU operations
	typedef enum logic [3:0] {
		ALU_ADD  = 4'h0,
		ALU_SUB  = 4'h1,
		ALU_AND  = 4'h2,
		ALU_OR   = 4'h3,
		ALU_XOR  = 4'h4,
		ALU_SLT  = 4'h5,
		ALU_SLTU = 4'h6,
		ALU_SLL  = 4'h7,
		ALU_SRL  = 4'h8,
		ALU_SRA  = 4'h9
	} alu_func_e;

	// Branch conditions and jumps
	typedef enum logic [2:0] {
		BR_EQ   = 3'h0,
		BR_NE   = 3'h1,
		BR_LT   = 3'h2,
		BR_GE   = 3'h3,
		BR_LTU  = 3'h4,
		BR_GEU  = 3'h5,
		BR_JAL  = 3'h6,
		BR_JALR = 3'h7
	} br_func_e;

	// One issued micro-op from the reservation stations
	typedef struct packed {
		xlen_t       opa_value;
		xlen_t       opb_value;
		xlen_t       pc;
		xlen_t       npc;
		inst_t       inst;
		opa_select_e opa_select;
		opb_select_e opb_select;
		alu_func_e   alu_func;
		br_func_e    br_func;
		preg_idx_t   dest_preg;
		rob_idx_t    rob_index;
	} rs_fu_packet_t;

endpackage

//--- logic/fu_result_if.sv
`timescale 1ns/1ps

// Held result of one function unit and its CDB grant
interface fu_result_if;
	import ooo_pkg::*;

	logic      valid;
	xlen_t     value;
	preg_idx_t preg;
	rob_idx_t  rob;
	logic      grant;

	// Function unit side
	modport fu (
		output valid, value, preg, rob,
		input  grant
	);

	// Arbiter side
	modport cdb (
		input  valid, value, preg, rob,
		output grant
	);

endinterface

//--- logic/operand_select.sv
`timescale 1ns/1ps

module operand_select (
	input  ooo_pkg::rs_fu_packet_t packet,
	output ooo_pkg::xlen_t         opa,
	output ooo_pkg::xlen_t         opb
);
	import ooo_pkg::*;

	xlen_t i_imm;
	xlen_t s_imm;
	xlen_t b_imm;
	xlen_t u_imm;
	xlen_t j_imm;

	// RV32 immediate formats, all sign-extended from bit 31
	assign i_imm = {{20{packet.inst[31]}}, packet.inst[31:20]};
	assign s_imm = {{20{packet.inst[31]}}, packet.inst[31:25], packet.inst[11:7]};
	assign b_imm = {{19{packet.inst[31]}}, packet.inst[31], packet.inst[7],
		packet.inst[30:25], packet.inst[11:8], 1'b0};
	assign u_imm = {packet.inst[31:12], 12'b0};
	assign j_imm = {{11{packet.inst[31]}}, packet.inst[31], packet.inst[19:12],
		packet.inst[20], packet.inst[30:21], 1'b0};

	// Operand A
	always_comb begin
		case (packet.opa_select)
			OPA_IS_RS1:  opa = packet.opa_value;
			OPA_IS_NPC:  opa = packet.npc;
			OPA_IS_PC:   opa = packet.pc;
			OPA_IS_ZERO: opa = '0;
			default:     opa = xlen_t'(32'hdeadfbac);
		endcase
	end

	// Operand B
	always_comb begin
		case (packet.opb_select)
			OPB_IS_RS2:   opb = packet.opb_value;
			OPB_IS_I_IMM: opb = i_imm;
			OPB_IS_S_IMM: opb = s_imm;
			OPB_IS_B_IMM: opb = b_imm;
			OPB_IS_U_IMM: opb = u_imm;
			OPB_IS_J_IMM: opb = j_imm;
			// Poison, shows up on the CDB if the issuer sent a bad select
			default:      opb = xlen_t'(32'hfacefeed);
		endcase
	end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue,
	input  ooo_pkg::rs_fu_packet_t packet,
	output logic                   ready,
	fu_result_if.fu                result
);
	import ooo_pkg::*;

	xlen_t     opa;
	xlen_t     opb;
	xlen_t     alu_value;
	logic      accept;
	logic      held_valid;
	xlen_t     held_value;
	preg_idx_t held_preg;
	rob_idx_t  held_rob;

	operand_select operand_select_inst (
		.packet (packet),
		.opa    (opa),
		.opb    (opb)
	);

	always_comb begin
		case (packet.alu_func)
			ALU_ADD:  alu_value = opa + opb;
			ALU_SUB:  alu_value = opa - opb;
			ALU_AND:  alu_value = opa & opb;
			ALU_OR:   alu_value = opa | opb;
			ALU_XOR:  alu_value = opa ^ opb;
			ALU_SLT:  alu_value = xlen_t'($signed(opa) < $signed(opb));
			ALU_SLTU: alu_value = xlen_t'(opa < opb);
			// Shift amount is the low five bits of B only
			ALU_SLL:  alu_value = opa << opb[4:0];
			ALU_SRL:  alu_value = opa >> opb[4:0];
			ALU_SRA:  alu_value = $signed(opa) >>> opb[4:0];
			default:  alu_value = xlen_t'(32'hfacebeec);
		endcase
	end

	// Free when empty or when the held result leaves this cycle
	assign ready  = !held_valid || result.grant;
	assign accept = issue && ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (accept) begin
			held_valid <= 1'b1;
		end else if (result.grant) begin
			held_valid <= 1'b0;
		end
	end

	// Result payload
	always_ff @(posedge clock) begin
		if (accept) begin
			held_value <= alu_value;
			held_preg  <= packet.dest_preg;
			held_rob   <= packet.rob_index;
		end
	end

	assign result.valid = held_valid;
	assign result.value = held_value;
	assign result.preg  = held_preg;
	assign result.rob   = held_rob;

endmodule

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue,
	input  ooo_pkg::rs_fu_packet_t packet,
	output logic                   ready,
	fu_result_if.fu                result,
	output logic                   br_resolve,
	output logic                   br_taken,
	output ooo_pkg::xlen_t         br_target
);
	import ooo_pkg::*;

	rs_fu_packet_t target_packet;
	xlen_t         target_base;
	xlen_t         target_offset;
	xlen_t         target_sum;
	xlen_t         target_next;
	logic          taken_next;
	logic          accept;
	logic          held_valid;
	xlen_t         held_value;
	preg_idx_t     held_preg;
	rob_idx_t      held_rob;
	logic          held_taken;
	xlen_t         held_target;

	// Target operands follow br_func, not the issued selects
	always_comb begin
		target_packet = packet;
		case (packet.br_func)
			BR_JAL: begin
				target_packet.opa_select = OPA_IS_PC;
				target_packet.opb_select = OPB_IS_J_IMM;
			end
			BR_JALR: begin
				target_packet.opa_select = OPA_IS_RS1;
				target_packet.opb_select = OPB_IS_I_IMM;
			end
			default: begin
				target_packet.opa_select = OPA_IS_PC;
				target_packet.opb_select = OPB_IS_B_IMM;
			end
		endcase
	end

	operand_select target_select (
		.packet (target_packet),
		.opa    (target_base),
		.opb    (target_offset)
	);

	assign target_sum  = target_base + target_offset;
	assign target_next = (packet.br_func == BR_JALR) ? (target_sum & ~xlen_t'(1)) : target_sum;

	always_comb begin
		case (packet.br_func)
			BR_EQ:   taken_next = packet.opa_value == packet.opb_value;
			BR_NE:   taken_next = packet.opa_value != packet.opb_value;
			BR_LT:   taken_next = $signed(packet.opa_value) < $signed(packet.opb_value);
			BR_GE:   taken_next = $signed(packet.opa_value) >= $signed(packet.opb_value);
			BR_LTU:  taken_next = packet.opa_value < packet.opb_value;
			BR_GEU:  taken_next = packet.opa_value >= packet.opb_value;
			// JAL and JALR
			default: taken_next = 1'b1;
		endcase
	end

	assign ready  = !held_valid || result.grant;
	assign accept = issue && ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (accept) begin
			held_valid <= 1'b1;
		end else if (result.grant) begin
			held_valid <= 1'b0;
		end
	end

	// Link value is NPC for every branch kind
	always_ff @(posedge clock) begin
		if (accept) begin
			held_value  <= packet.npc;
			held_preg   <= packet.dest_preg;
			held_rob    <= packet.rob_index;
			held_taken  <= taken_next;
			held_target <= target_next;
		end
	end

	assign result.valid = held_valid;
	assign result.value = held_value;
	assign result.preg  = held_preg;
	assign result.rob   = held_rob;

	// Resolution is visible when the result goes out on the CDB
	assign br_resolve = result.grant;
	assign br_taken   = held_taken;
	assign br_target  = held_target;

endmodule

//--- logic/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
	input  logic                clock,
	input  logic                reset,
	input  logic                cdb_stall,
	fu_result_if.cdb            alu_res,
	fu_result_if.cdb            br_res,
	output logic                cdb_valid,
	output ooo_pkg::xlen_t      cdb_value,
	output ooo_pkg::preg_idx_t  cdb_preg,
	output ooo_pkg::rob_idx_t   cdb_rob
);

	// Round-robin pointer, low favours the ALU
	logic favour_br;

	always_comb begin
		alu_res.grant = 1'b0;
		br_res.grant  = 1'b0;
		if (!cdb_stall) begin
			if (alu_res.valid && br_res.valid) begin
				br_res.grant  = favour_br;
				alu_res.grant = !favour_br;
			end else begin
				alu_res.grant = alu_res.valid;
				br_res.grant  = br_res.valid;
			end
		end
	end

	// Priority passes to the unit that was not served
	always_ff @(posedge clock) begin
		if (reset) begin
			favour_br <= 1'b0;
		end else if (alu_res.grant) begin
			favour_br <= 1'b1;
		end else if (br_res.grant) begin
			favour_br <= 1'b0;
		end
	end

	assign cdb_valid = alu_res.grant || br_res.grant;

	// Bus payload from the winner, ALU fields when idle
	always_comb begin
		if (br_res.grant) begin
			cdb_value = br_res.value;
			cdb_preg  = br_res.preg;
			cdb_rob   = br_res.rob;
		end else begin
			cdb_value = alu_res.value;
			cdb_preg  = alu_res.preg;
			cdb_rob   = alu_res.rob;
		end
	end

endmodule

//--- logic/fu_cluster.sv
`timescale 1ns/1ps

module fu_cluster (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   alu_issue,
	input  logic                   br_issue,
	input  logic                   cdb_stall,
	input  ooo_pkg::rs_fu_packet_t packet,
	output logic                   alu_ready,
	output logic                   br_ready,
	output logic                   cdb_valid,
	output ooo_pkg::xlen_t         cdb_value,
	output ooo_pkg::preg_idx_t     cdb_preg,
	output ooo_pkg::rob_idx_t      cdb_rob,
	output logic                   br_resolve,
	output logic                   br_taken,
	output ooo_pkg::xlen_t         br_target
);

	// Held results toward the arbiter
	fu_result_if alu_res ();
	fu_result_if br_res ();

	// Both units see the shared issue bus
	alu alu_inst (
		.clock  (clock),
		.reset  (reset),
		.issue  (alu_issue),
		.packet (packet),
		.ready  (alu_ready),
		.result (alu_res.fu)
	);

	branch_unit branch_unit_inst (
		.clock      (clock),
		.reset      (reset),
		.issue      (br_issue),
		.packet     (packet),
		.ready      (br_ready),
		.result     (br_res.fu),
		.br_resolve (br_resolve),
		.br_taken   (br_taken),
		.br_target  (br_target)
	);

	cdb_arbiter cdb_arbiter_inst (
		.clock     (clock),
		.reset     (reset),
		.cdb_stall (cdb_stall),
		.alu_res   (alu_res.cdb),
		.br_res    (br_res.cdb),
		.cdb_valid (cdb_valid),
		.cdb_value (cdb_value),
		.cdb_preg  (cdb_preg),
		.cdb_rob   (cdb_rob)
	);

endmodule

//--- bench/fu_cluster_tb.sv
`timescale 1ns/1ps

module fu_cluster_tb;
	import ooo_pkg::*;

	localparam int CLOCK_PERIOD = 100;
	localparam int ISSUE_COUNT  = 400;

	// One expected CDB broadcast, plus branch outcome
	typedef struct packed {
		xlen_t     value;
		preg_idx_t preg;
		rob_idx_t  rob;
		logic      taken;
		xlen_t     target;
	} expect_t;

	logic          clock;
	logic          reset;
	logic          alu_issue;
	logic          br_issue;
	logic          cdb_stall;
	rs_fu_packet_t packet;
	logic          alu_ready;
	logic          br_ready;
	logic          cdb_valid;
	xlen_t         cdb_value;
	preg_idx_t     cdb_preg;
	rob_idx_t      cdb_rob;
	logic          br_resolve;
	logic          br_taken;
	xlen_t         br_target;

	integer   seed;
	int       issued;
	int       word_errors;
	int       index_errors;
	int       bit_errors;
	rob_idx_t rob_count;

	// Model state
	expect_t alu_q[$];
	expect_t br_q[$];
	expect_t pending;
	logic    favour_br;
	logic    issue_alu_now;
	logic    issue_br_now;
	logic    alu_grant_exp;
	logic    br_grant_exp;
	logic    alu_ready_exp;
	logic    br_ready_exp;

	fu_cluster fu_cluster_inst (
		.clock      (clock),
		.reset      (reset),
		.alu_issue  (alu_issue),
		.br_issue   (br_issue),
		.cdb_stall  (cdb_stall),
		.packet     (packet),
		.alu_ready  (alu_ready),
		.br_ready   (br_ready),
		.cdb_valid  (cdb_valid),
		.cdb_value  (cdb_value),
		.cdb_preg   (cdb_preg),
		.cdb_rob    (cdb_rob),
		.br_resolve (br_resolve),
		.br_taken   (br_taken),
		.br_target  (br_target)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic check_word(input string name, input xlen_t actual, input xlen_t expected);
		if (actual !== expected) begin
			word_errors++;
			$display("[FAIL] %0d ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_preg(input string name, input preg_idx_t actual,
		input preg_idx_t expected);
		if (actual !== expected) begin
			index_errors++;
			$display("[FAIL] %0d ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_rob(input string name, input rob_idx_t actual, input rob_idx_t expected);
		if (actual !== expected) begin
			index_errors++;
			$display("[FAIL] %0d ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			bit_errors++;
			$display("[FAIL] %0d ns: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	// Sign-extend the low bits of v
	function automatic xlen_t sext(input xlen_t v, input int bits);
		xlen_t t;
		t = v << (32 - bits);
		return xlen_t'($signed(t) >>> (32 - bits));
	endfunction

	function automatic xlen_t operand_a(input rs_fu_packet_t p);
		case (p.opa_select)
			OPA_IS_NPC:  return p.npc;
			OPA_IS_PC:   return p.pc;
			OPA_IS_ZERO: return 32'h0;
			default:     return p.opa_value;
		endcase
	endfunction

	function automatic xlen_t operand_b(input rs_fu_packet_t p);
		inst_t i;
		i = p.inst;
		case (p.opb_select)
			OPB_IS_I_IMM: return sext(xlen_t'(i[31:20]), 12);
			OPB_IS_S_IMM: return sext(xlen_t'({i[31:25], i[11:7]}), 12);
			OPB_IS_B_IMM: return sext(xlen_t'({i[31], i[7], i[30:25], i[11:8], 1'b0}), 13);
			OPB_IS_U_IMM: return {i[31:12], 12'h000};
			OPB_IS_J_IMM: return sext(xlen_t'({i[31], i[19:12], i[20], i[30:21], 1'b0}), 21);
			default:      return p.opb_value;
		endcase
	endfunction

	function automatic expect_t expect_alu(input rs_fu_packet_t p);
		expect_t e;
		xlen_t   a;
		xlen_t   b;
		logic [4:0] sh;
		a = operand_a(p);
		b = operand_b(p);
		sh = b[4:0];
		e = '0;
		e.preg = p.dest_preg;
		e.rob = p.rob_index;
		case (p.alu_func)
			ALU_SUB:  e.value = a - b;
			ALU_AND:  e.value = a & b;
			ALU_OR:   e.value = a | b;
			ALU_XOR:  e.value = a ^ b;
			// Signed compare by flipping the sign bits
			ALU_SLT:  e.value = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
			ALU_SLTU: e.value = {31'b0, a < b};
			ALU_SLL:  e.value = a << sh;
			ALU_SRL:  e.value = a >> sh;
			ALU_SRA:  e.value = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			default:  e.value = a + b;
		endcase
		return e;
	endfunction

	function automatic expect_t expect_branch(input rs_fu_packet_t p);
		expect_t e;
		xlen_t   a;
		xlen_t   b;
		xlen_t   sum;
		logic    lt;
		inst_t   i;
		a = p.opa_value;
		b = p.opb_value;
		i = p.inst;
		lt = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
		e = '0;
		e.value = p.npc;
		e.preg = p.dest_preg;
		e.rob = p.rob_index;
		e.taken = 1'b1;
		e.target = p.pc + sext(xlen_t'({i[31], i[7], i[30:25], i[11:8], 1'b0}), 13);
		case (p.br_func)
			BR_EQ:  e.taken = a == b;
			BR_NE:  e.taken = a != b;
			BR_LT:  e.taken = lt;
			BR_GE:  e.taken = !lt;
			BR_LTU: e.taken = a < b;
			BR_GEU: e.taken = !(a < b);
			BR_JAL: e.target = p.pc + sext(xlen_t'({i[31], i[19:12], i[20], i[30:21], 1'b0}), 21);
			default: begin
				sum = p.opa_value + sext(xlen_t'(i[31:20]), 12);
				e.target = {sum[31:1], 1'b0};
			end
		endcase
		return e;
	endfunction

	task automatic build_packet(output rs_fu_packet_t p);
		logic [31:0] r;
		r = $random(seed);
		p.opa_value = $random(seed);
		// Equal operands now and then for compares and branches
		p.opb_value = (r[1:0] == 2'b00) ? p.opa_value : $random(seed);
		p.pc = $random(seed);
		p.pc = {p.pc[31:2], 2'b00};
		p.npc = p.pc + 32'd4;
		p.inst = $random(seed);
		p.opa_select = opa_select_e'(r[3:2]);
		p.opb_select = opb_select_e'(3'(r[15:8] % 6));
		p.alu_func = alu_func_e'(4'(r[23:16] % 10));
		p.br_func = br_func_e'(r[6:4]);
		p.dest_preg = r[29:24];
		p.rob_index = rob_count;
		// Immediate seen through ADD with a zero operand A
		if (r[31:30] == 2'b00) begin
			p.opa_select = OPA_IS_ZERO;
			p.alu_func = ALU_ADD;
		end
	endtask

	// Predict this cycle and drive the inputs for it
	task automatic plan_cycle();
		logic [31:0]   r;
		logic          stall;
		logic          want_alu;
		logic          want_br;
		rs_fu_packet_t p;
		r = $random(seed);
		stall = (r[1:0] == 2'b00);
		want_alu = alu_q.size() != 0;
		want_br = br_q.size() != 0;
		br_grant_exp = !stall && want_br && (!want_alu || favour_br);
		alu_grant_exp = !stall && want_alu && !br_grant_exp;
		alu_ready_exp = !want_alu || alu_grant_exp;
		br_ready_exp = !want_br || br_grant_exp;
		issue_alu_now = 1'b0;
		issue_br_now = 1'b0;
		if (issued < ISSUE_COUNT && r[4:3] != 2'b00) begin
			if (r[2]) begin
				issue_br_now = br_ready_exp;
			end else begin
				issue_alu_now = alu_ready_exp;
			end
		end
		build_packet(p);
		if (issue_alu_now) begin
			pending = expect_alu(p);
		end else if (issue_br_now) begin
			pending = expect_branch(p);
		end
		if (issue_alu_now || issue_br_now) begin
			issued++;
			rob_count = rob_count + 1'b1;
		end
		cdb_stall <= stall;
		alu_issue <= issue_alu_now;
		br_issue <= issue_br_now;
		packet <= p;
	endtask

	task automatic check_broadcast(input expect_t e);
		check_word("cdb_value", cdb_value, e.value);
		check_preg("cdb_preg", cdb_preg, e.preg);
		check_rob("cdb_rob", cdb_rob, e.rob);
	endtask

	task automatic check_cycle();
		expect_t head;
		check_bit("alu_ready", alu_ready, alu_ready_exp);
		check_bit("br_ready", br_ready, br_ready_exp);
		check_bit("cdb_valid", cdb_valid, alu_grant_exp || br_grant_exp);
		check_bit("br_resolve", br_resolve, br_grant_exp);
		if (alu_grant_exp) begin
			head = alu_q.pop_front();
			check_broadcast(head);
			favour_br = 1'b1;
		end else if (br_grant_exp) begin
			head = br_q.pop_front();
			check_broadcast(head);
			check_bit("br_taken", br_taken, head.taken);
			check_word("br_target", br_target, head.target);
			favour_br = 1'b0;
		end
		// Accepted at the coming edge
		if (issue_alu_now) begin
			alu_q.push_back(pending);
		end
		if (issue_br_now) begin
			br_q.push_back(pending);
		end
	endtask

	initial begin
		#(20 * ISSUE_COUNT * CLOCK_PERIOD);
		$display("Watchdog expired after %0d of %0d issues", issued, ISSUE_COUNT);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		alu_issue = 1'b0;
		br_issue = 1'b0;
		cdb_stall = 1'b0;
		packet = '0;
		seed = 23630;
		issued = 0;
		word_errors = 0;
		index_errors = 0;
		bit_errors = 0;
		rob_count = '0;
		favour_br = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_bit("alu_ready", alu_ready, 1'b1);
		check_bit("br_ready", br_ready, 1'b1);
		check_bit("cdb_valid", cdb_valid, 1'b0);
		check_bit("br_resolve", br_resolve, 1'b0);
		@(posedge clock);
		reset <= 1'b0;
		while (issued < ISSUE_COUNT || alu_q.size() != 0 || br_q.size() != 0) begin
			plan_cycle();
			@(negedge clock);
			check_cycle();
			@(posedge clock);
		end
		$display("Errors: %0d value, %0d index, %0d control", word_errors, index_errors,
			bit_errors);
		if (word_errors + index_errors + bit_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+logic
logic/ooo_pkg.sv
logic/fu_result_if.sv
logic/operand_select.sv
logic/alu.sv
logic/branch_unit.sv
logic/cdb_arbiter.sv
logic/fu_cluster.sv
bench/fu_cluster_tb.sv

//--- Makefile
SOURCES := compile.f $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: run clean

obj_dir/Vfu_cluster_tb: $(SOURCES)
	verilator --binary --timing -f compile.f --top-module fu_cluster_tb

run: obj_dir/Vfu_cluster_tb
	@out="$$(./obj_dir/Vfu_cluster_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
